// File: Makefile
# Verilator build and run for the mailbox bridge testbench

TOP := tb_bridge_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)

# the log decides pass or fail
run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bridge_cfg.svh
// mailbox bridge constants
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// ----------------------------------------
// widths
// ----------------------------------------
// payload and bus data width
`define BRIDGE_WORD_W       32
// one enable per data byte
`define BRIDGE_BE_W         4
`define BRIDGE_BUS_ADDR_W   32
// four host registers
`define BRIDGE_HOST_ADDR_W  2

// instruction slot and section address slot
`define BRIDGE_NUM_SLOTS    2

// ----------------------------------------
// host register numbers
// ----------------------------------------
`define REG_INSTR           2'd0
`define REG_SECTION_ADDR    2'd1
`define REG_STATUS          2'd2
`define REG_RESULT          2'd3

// ----------------------------------------
// bus word offsets, addr[3:2]
// ----------------------------------------
`define OFS_INSTR           2'd0
`define OFS_SECTION_ADDR    2'd1
`define OFS_STATUS          2'd2
`define OFS_RESULT          2'd3

// slot indices
`define SLOT_INSTR          0
`define SLOT_SECTION_ADDR   1

`endif

// File: bridge_pkg.sv
// mailbox bridge types
`include "bridge_cfg.svh"

package bridge_pkg;

  // ----------------------------------------
  // data path
  // ----------------------------------------
  // one payload or bus word
  typedef logic [`BRIDGE_WORD_W-1:0] word_t;

  // byte enables, bit n covers data[8n+7:8n]
  typedef logic [`BRIDGE_BE_W-1:0] be_t;

  // ----------------------------------------
  // addressing
  // ----------------------------------------
  // host register number
  typedef logic [`BRIDGE_HOST_ADDR_W-1:0] host_addr_t;

  // full byte address from the core
  typedef logic [`BRIDGE_BUS_ADDR_W-1:0] bus_addr_t;

  // ----------------------------------------
  // status
  // ----------------------------------------
  // one flag per slot, also the core status word before zero extension
  typedef logic [`BRIDGE_NUM_SLOTS-1:0] slot_valid_t;

  // host status byte
  // bit 0 instr valid, bit 1 section addr valid, bit 2 result pending
  typedef struct packed {
    logic [4:0] reserved;
    logic       result_pending;
    logic       addr_valid;
    logic       instr_valid;
  } host_status_t;

endpackage

// File: bridge_top.sv
// host to core command mailbox
`timescale 1ns/100ps
`include "bridge_cfg.svh"

module bridge_top (
  input  logic                   heep_clk,
  input  logic                   rst_instr_valid_to_regs,
  // host register port
  input  bridge_pkg::host_addr_t host_addr_i,
  input  bridge_pkg::word_t      host_wdata_i,
  input  logic                   host_wr_i,
  input  logic                   host_rd_i,
  output bridge_pkg::word_t      host_rdata_o,
  // obi slave port toward the core
  input  logic                   obi_req_i,
  input  logic                   obi_we_i,
  input  bridge_pkg::be_t        obi_be_i,
  input  bridge_pkg::bus_addr_t  obi_addr_i,
  input  bridge_pkg::word_t      obi_wdata_i,
  output logic                   obi_gnt_o,
  output logic                   obi_rvalid_o,
  output bridge_pkg::word_t      obi_rdata_o
);

  // result path from bus to host side
  logic              result_we;
  bridge_pkg::word_t result_wdata;
  bridge_pkg::be_t   result_be;

  // one link per slot
  mailbox_if slot_if [0:`BRIDGE_NUM_SLOTS-1] ();

  // ----------------------------------------
  // host side
  // ----------------------------------------
  host_reg_decoder u_host_reg_decoder (
    .heep_clk                (heep_clk),
    .rst_instr_valid_to_regs (rst_instr_valid_to_regs),
    .host_addr_i             (host_addr_i),
    .host_wdata_i            (host_wdata_i),
    .host_wr_i               (host_wr_i),
    .host_rd_i               (host_rd_i),
    .host_rdata_o            (host_rdata_o),
    .slots                   (slot_if),
    .result_we_i             (result_we),
    .result_wdata_i          (result_wdata),
    .result_be_i             (result_be)
  );

  // ----------------------------------------
  // mailbox slots
  // ----------------------------------------
  // slot 0 instruction, slot 1 section address
  for (genvar i = 0; i < `BRIDGE_NUM_SLOTS; i++) begin : g_slot
    mailbox_slot u_mailbox_slot (
      .heep_clk                (heep_clk),
      .rst_instr_valid_to_regs (rst_instr_valid_to_regs),
      .slot                    (slot_if[i])
    );
  end

  // ----------------------------------------
  // core side
  // ----------------------------------------
  obi_slave_bridge u_obi_slave_bridge (
    .heep_clk                (heep_clk),
    .rst_instr_valid_to_regs (rst_instr_valid_to_regs),
    .obi_req_i               (obi_req_i),
    .obi_we_i                (obi_we_i),
    .obi_be_i                (obi_be_i),
    .obi_addr_i              (obi_addr_i),
    .obi_wdata_i             (obi_wdata_i),
    .obi_gnt_o               (obi_gnt_o),
    .obi_rvalid_o            (obi_rvalid_o),
    .obi_rdata_o             (obi_rdata_o),
    .slots                   (slot_if),
    .result_we_o             (result_we),
    .result_wdata_o          (result_wdata),
    .result_be_o             (result_be)
  );

endmodule

// File: files.f
+incdir+.
bridge_pkg.sv
mailbox_if.sv
mailbox_slot.sv
host_reg_decoder.sv
obi_slave_bridge.sv
bridge_top.sv
tb_bridge_top.sv

// File: host_reg_decoder.sv
// host register decoder
`timescale 1ns/100ps
`include "bridge_cfg.svh"

module host_reg_decoder (
  input  logic                   heep_clk,
  input  logic                   rst_instr_valid_to_regs,
  // host register port
  input  bridge_pkg::host_addr_t host_addr_i,
  input  bridge_pkg::word_t      host_wdata_i,
  input  logic                   host_wr_i,
  input  logic                   host_rd_i,
  output bridge_pkg::word_t      host_rdata_o,
  // mailbox slots, filled from here
  mailbox_if.loader              slots [0:`BRIDGE_NUM_SLOTS-1],
  // result writes coming from the core
  input  logic                   result_we_i,
  input  bridge_pkg::word_t      result_wdata_i,
  input  bridge_pkg::be_t        result_be_i
);

  bridge_pkg::slot_valid_t  load_vec;
  bridge_pkg::slot_valid_t  slot_valid;
  bridge_pkg::word_t        slot_data [0:`BRIDGE_NUM_SLOTS-1];
  bridge_pkg::word_t        result_q;
  logic                     result_pending_q;
  logic                     result_rd;
  bridge_pkg::host_status_t host_status;

  // ----------------------------------------
  // slot loading
  // ----------------------------------------
  // status and result registers are read only from the host
  always_comb begin
    load_vec = '0;
    if (host_wr_i) begin
      load_vec[`SLOT_INSTR]        = (host_addr_i == `REG_INSTR);
      load_vec[`SLOT_SECTION_ADDR] = (host_addr_i == `REG_SECTION_ADDR);
    end
  end

  // every slot sees the same write data
  for (genvar i = 0; i < `BRIDGE_NUM_SLOTS; i++) begin : g_slot
    assign slots[i].load      = load_vec[i];
    assign slots[i].load_data = host_wdata_i;
    assign slot_valid[i]      = slots[i].valid;
    assign slot_data[i]       = slots[i].data;
  end

  // ----------------------------------------
  // result register
  // ----------------------------------------
  // bytewise merge, unselected bytes keep the old result
  always_ff @(posedge heep_clk) begin
    if (!rst_instr_valid_to_regs) begin
      result_q <= '0;
    end else if (result_we_i) begin
      for (int b = 0; b < `BRIDGE_BE_W; b++) begin
        if (result_be_i[b]) begin
          result_q[b*8 +: 8] <= result_wdata_i[b*8 +: 8];
        end
      end
    end
  end

  assign result_rd = host_rd_i && (host_addr_i == `REG_RESULT);

  // a new result beats a host read in the same cycle
  always_ff @(posedge heep_clk) begin
    if (!rst_instr_valid_to_regs) begin
      result_pending_q <= 1'b0;
    end else if (result_we_i) begin
      result_pending_q <= 1'b1;
    end else if (result_rd) begin
      result_pending_q <= 1'b0;
    end
  end

  // ----------------------------------------
  // host read path
  // ----------------------------------------
  always_comb begin
    host_status                = '0;
    host_status.instr_valid    = slot_valid[`SLOT_INSTR];
    host_status.addr_valid     = slot_valid[`SLOT_SECTION_ADDR];
    host_status.result_pending = result_pending_q;
  end

  // purely combinational from the address
  always_comb begin
    case (host_addr_i)
      `REG_INSTR:        host_rdata_o = slot_data[`SLOT_INSTR];
      `REG_SECTION_ADDR: host_rdata_o = slot_data[`SLOT_SECTION_ADDR];
      `REG_STATUS:       host_rdata_o = bridge_pkg::word_t'(host_status);
      `REG_RESULT:       host_rdata_o = result_q;
      default:           host_rdata_o = '0;
    endcase
  end

  // a slot flag comes up only after a host write to a slot register
  a_load_needs_host_wr : assert property (
    @(posedge heep_clk) disable iff (!rst_instr_valid_to_regs)
    (|(slot_valid & ~$past(slot_valid))) |->
      $past(host_wr_i) && ($past(host_addr_i) inside {`REG_INSTR, `REG_SECTION_ADDR})
  ) else $error("slot load without a host write");

endmodule

// File: mailbox_if.sv
// single mailbox slot link
`timescale 1ns/100ps

interface mailbox_if;

  // written by the host side
  logic              load;
  bridge_pkg::word_t load_data;
  // consumed by the bus side
  logic              take;
  // slot contents
  logic              valid;
  bridge_pkg::word_t data;

  // host side fills the slot
  modport loader (
    output load,
    output load_data,
    input  valid,
    input  data
  );

  // core side empties the slot
  modport drainer (
    output take,
    input  valid,
    input  data
  );

  // the storage itself
  modport slot (
    input  load,
    input  load_data,
    input  take,
    output valid,
    output data
  );

endinterface

// File: mailbox_slot.sv
// mailbox slot storage
`timescale 1ns/100ps

module mailbox_slot (
  input logic     heep_clk,
  input logic     rst_instr_valid_to_regs,
  mailbox_if.slot slot
);

  logic              valid_q;
  bridge_pkg::word_t data_q;

  // ----------------------------------------
  // valid flag
  // ----------------------------------------
  // load beats take, so a same cycle refill stays valid
  always_ff @(posedge heep_clk) begin
    if (!rst_instr_valid_to_regs) begin
      valid_q <= 1'b0;
    end else if (slot.load) begin
      valid_q <= 1'b1;
    end else if (slot.take) begin
      valid_q <= 1'b0;
    end
  end

  // payload, overwritten on every load
  // take leaves the word in place
  always_ff @(posedge heep_clk) begin
    if (slot.load) begin
      data_q <= slot.load_data;
    end
  end

  assign slot.valid = valid_q;
  assign slot.data  = data_q;

  // ----------------------------------------
  // checks
  // ----------------------------------------
  // flag only comes up from a host load
  a_valid_rise_needs_load : assert property (
    @(posedge heep_clk) disable iff (!rst_instr_valid_to_regs)
    $rose(slot.valid) |-> $past(slot.load)
  ) else $error("slot valid rose without a load");

  // a bus take never disturbs the payload
  a_data_held_without_load : assert property (
    @(posedge heep_clk) disable iff (!rst_instr_valid_to_regs)
    !$past(slot.load) |-> $stable(slot.data)
  ) else $error("slot data changed without a load");

endmodule

// File: obi_slave_bridge.sv
// obi slave side of the mailbox
`timescale 1ns/100ps
`include "bridge_cfg.svh"

module obi_slave_bridge (
  input  logic                  heep_clk,
  input  logic                  rst_instr_valid_to_regs,
  // obi slave port
  input  logic                  obi_req_i,
  input  logic                  obi_we_i,
  input  bridge_pkg::be_t       obi_be_i,
  input  bridge_pkg::bus_addr_t obi_addr_i,
  input  bridge_pkg::word_t     obi_wdata_i,
  output logic                  obi_gnt_o,
  output logic                  obi_rvalid_o,
  output bridge_pkg::word_t     obi_rdata_o,
  // mailbox slots, drained from here
  mailbox_if.drainer            slots [0:`BRIDGE_NUM_SLOTS-1],
  // result write toward the host side
  output logic                  result_we_o,
  output bridge_pkg::word_t     result_wdata_o,
  output bridge_pkg::be_t       result_be_o
);

  logic [1:0]              word_ofs;
  logic                    rd_req;
  logic                    wr_req;
  bridge_pkg::slot_valid_t take_vec;
  bridge_pkg::slot_valid_t slot_valid;
  bridge_pkg::word_t       slot_data [0:`BRIDGE_NUM_SLOTS-1];
  bridge_pkg::word_t       rdata_d;
  bridge_pkg::word_t       rdata_q;
  logic                    rvalid_q;

  // ----------------------------------------
  // request decode
  // ----------------------------------------
  // no backpressure, every request is granted at once
  assign obi_gnt_o = obi_req_i;

  // word select only, upper address bits are don't care
  assign word_ofs = obi_addr_i[3:2];
  assign rd_req   = obi_req_i && !obi_we_i;
  assign wr_req   = obi_req_i && obi_we_i;

  // reading a slot register consumes it in the grant cycle
  always_comb begin
    take_vec = '0;
    if (rd_req) begin
      take_vec[`SLOT_INSTR]        = (word_ofs == `OFS_INSTR);
      take_vec[`SLOT_SECTION_ADDR] = (word_ofs == `OFS_SECTION_ADDR);
    end
  end

  for (genvar i = 0; i < `BRIDGE_NUM_SLOTS; i++) begin : g_slot
    assign slots[i].take = take_vec[i];
    assign slot_valid[i] = slots[i].valid;
    assign slot_data[i]  = slots[i].data;
  end

  // result register accepts byte writes only at its own offset
  assign result_we_o    = wr_req && (word_ofs == `OFS_RESULT);
  assign result_wdata_o = obi_wdata_i;
  assign result_be_o    = obi_be_i;

  // ----------------------------------------
  // read data
  // ----------------------------------------
  // payload is sampled before the take clears the flag
  // result reads back as zero on this side
  always_comb begin
    rdata_d = '0;
    if (rd_req) begin
      case (word_ofs)
        `OFS_INSTR:        rdata_d = slot_data[`SLOT_INSTR];
        `OFS_SECTION_ADDR: rdata_d = slot_data[`SLOT_SECTION_ADDR];
        `OFS_STATUS:       rdata_d = bridge_pkg::word_t'(slot_valid);
        default:           rdata_d = '0;
      endcase
    end
  end

  // one cycle response, writes get an rvalid too
  always_ff @(posedge heep_clk) begin
    if (!rst_instr_valid_to_regs) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i;
    end
  end

  always_ff @(posedge heep_clk) begin
    if (obi_req_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign obi_rvalid_o = rvalid_q;
  assign obi_rdata_o  = rdata_q;

  // response strictly one cycle after the request
  a_rvalid_after_req : assert property (
    @(posedge heep_clk) disable iff (!rst_instr_valid_to_regs)
    obi_rvalid_o |-> $past(obi_req_i)
  ) else $error("rvalid without a request in the previous cycle");

endmodule

// File: tb_bridge_vectors.svh
// mailbox bridge test vectors
`ifndef TB_BRIDGE_VECTORS_SVH
`define TB_BRIDGE_VECTORS_SVH

// columns: operation, host register or bus word offset, write data, byte enables, expected
// status rows hold the expected host status byte in bits 7 to 0
task automatic fill_vectors();
  // ----------------------------------------
  // reset state
  // ----------------------------------------
  add_op(OP_HOST_RD, `REG_STATUS,       '0,           '0,      32'h0000_0000);
  add_op(OP_BUS_RD,  `OFS_STATUS,       '0,           '0,      32'h0000_0000);

  // ----------------------------------------
  // host fills both slots
  // ----------------------------------------
  add_op(OP_HOST_WR, `REG_INSTR,        instr_a,      '0,      '0);
  add_op(OP_HOST_WR, `REG_SECTION_ADDR, addr_a,       '0,      '0);
  add_op(OP_HOST_RD, `REG_STATUS,       '0,           '0,      32'h0000_0003);
  add_op(OP_HOST_RD, `REG_INSTR,        '0,           '0,      instr_a);
  add_op(OP_HOST_RD, `REG_SECTION_ADDR, '0,           '0,      addr_a);
  add_op(OP_BUS_RD,  `OFS_STATUS,       '0,           '0,      32'h0000_0003);

  // ----------------------------------------
  // core drains the slots one at a time
  // ----------------------------------------
  add_op(OP_BUS_RD,  `OFS_INSTR,        '0,           '0,      instr_a);
  add_op(OP_HOST_RD, `REG_STATUS,       '0,           '0,      32'h0000_0002);
  add_op(OP_BUS_RD,  `OFS_SECTION_ADDR, '0,           '0,      addr_a);
  add_op(OP_HOST_RD, `REG_STATUS,       '0,           '0,      32'h0000_0000);
  add_op(OP_BUS_RD,  `OFS_STATUS,       '0,           '0,      32'h0000_0000);

  // ----------------------------------------
  // result write back, full then partial
  // ----------------------------------------
  add_op(OP_BUS_WR,  `OFS_RESULT,       result_full,  4'b1111, '0);
  add_op(OP_HOST_RD, `REG_STATUS,       '0,           '0,      32'h0000_0004);
  add_op(OP_HOST_RD, `REG_RESULT,       '0,           '0,      result_full);
  add_op(OP_HOST_RD, `REG_STATUS,       '0,           '0,      32'h0000_0000);
  add_op(OP_BUS_WR,  `OFS_RESULT,       result_patch, 4'b0101, '0);
  add_op(OP_HOST_RD, `REG_STATUS,       '0,           '0,      32'h0000_0004);
  add_op(OP_HOST_RD, `REG_RESULT,       '0,           '0,
         merge_bytes(result_full, result_patch, 4'b0101));
  add_op(OP_HOST_RD, `REG_STATUS,       '0,           '0,      32'h0000_0000);
  // result is not readable from the core
  add_op(OP_BUS_RD,  `OFS_RESULT,       '0,           '0,      32'h0000_0000);

  // ----------------------------------------
  // refill after a take
  // ----------------------------------------
  add_op(OP_HOST_WR, `REG_INSTR,        instr_b,      '0,      '0);
  add_op(OP_HOST_RD, `REG_STATUS,       '0,           '0,      32'h0000_0001);
  add_op(OP_BUS_RD,  `OFS_INSTR,        '0,           '0,      instr_b);
  add_op(OP_HOST_RD, `REG_STATUS,       '0,           '0,      32'h0000_0000);
  // status register ignores host writes
  add_op(OP_HOST_WR, `REG_STATUS,       instr_a,      '0,      '0);
  add_op(OP_HOST_RD, `REG_STATUS,       '0,           '0,      32'h0000_0000);
  // payload survives the take
  add_op(OP_HOST_RD, `REG_INSTR,        '0,           '0,      instr_b);
endtask

`endif

// File: tb_bridge_top.sv
// mailbox bridge testbench
`timescale 1ns/100ps
`include "bridge_cfg.svh"

module tb_bridge_top;

  typedef enum logic [1:0] {
    OP_HOST_WR,
    OP_HOST_RD,
    OP_BUS_RD,
    OP_BUS_WR
  } op_e;

  // one table row
  typedef struct {
    op_e               op;
    logic [1:0]        ofs;
    bridge_pkg::word_t data;
    bridge_pkg::be_t   be;
    bridge_pkg::word_t exp;
  } vec_t;

  logic                   heep_clk;
  logic                   rst_instr_valid_to_regs;
  bridge_pkg::host_addr_t host_addr_i;
  bridge_pkg::word_t      host_wdata_i;
  logic                   host_wr_i;
  logic                   host_rd_i;
  bridge_pkg::word_t      host_rdata_o;
  logic                   obi_req_i;
  logic                   obi_we_i;
  bridge_pkg::be_t        obi_be_i;
  bridge_pkg::bus_addr_t  obi_addr_i;
  bridge_pkg::word_t      obi_wdata_i;
  logic                   obi_gnt_o;
  logic                   obi_rvalid_o;
  bridge_pkg::word_t      obi_rdata_o;

  vec_t vecs[$];
  int   cycle_count = 0;
  int   cycle_limit = 1000;

  // random payloads, drawn before the table is built
  bridge_pkg::word_t instr_a;
  bridge_pkg::word_t addr_a;
  bridge_pkg::word_t instr_b;
  bridge_pkg::word_t result_full;
  bridge_pkg::word_t result_patch;

  bridge_top dut0 (.*);

  // 8 ns period
  always #4 heep_clk = ~heep_clk;

  // ----------------------------------------
  // timeout
  // ----------------------------------------
  always @(posedge heep_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: no finish after %0d clock cycles", cycle_limit);
      $display("Simulation failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // ----------------------------------------
  // table helpers
  // ----------------------------------------
  task automatic add_op(input op_e op, input logic [1:0] ofs, input bridge_pkg::word_t data,
                        input bridge_pkg::be_t be, input bridge_pkg::word_t exp);
    vec_t v;
    v.op   = op;
    v.ofs  = ofs;
    v.data = data;
    v.be   = be;
    v.exp  = exp;
    vecs.push_back(v);
  endtask

  // expected result after a byte-enabled write
  function automatic bridge_pkg::word_t merge_bytes(input bridge_pkg::word_t old_word,
                                                    input bridge_pkg::word_t new_word,
                                                    input bridge_pkg::be_t be);
    bridge_pkg::word_t mask;
    // each enable bit widened to a full byte lane
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  `include "tb_bridge_vectors.svh"

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_word(input bridge_pkg::word_t got, input bridge_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s read %08h, expected %08h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "word compare failed");
    end
  endtask

  task automatic check_status(input bridge_pkg::host_status_t got,
                              input bridge_pkg::host_status_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s status %02h, expected %02h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "status compare failed");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "handshake compare failed");
    end
  endtask

  // ----------------------------------------
  // drivers
  // ----------------------------------------
  task automatic drive_idle();
    host_wr_i = 1'b0;
    host_rd_i = 1'b0;
    obi_req_i = 1'b0;
    obi_we_i  = 1'b0;
  endtask

  // upper address bits are arbitrary, word select in bits 3 to 2
  function automatic bridge_pkg::bus_addr_t bus_address(input logic [1:0] ofs);
    return {28'h2000_010, ofs, 2'b00};
  endfunction

  task automatic apply_vector(input int idx);
    vec_t  v;
    string tag;
    v   = vecs[idx];
    tag = $sformatf("entry %0d", idx);
    @(negedge heep_clk);
    drive_idle();
    case (v.op)
      OP_HOST_WR: begin
        host_addr_i  = v.ofs;
        host_wdata_i = v.data;
        host_wr_i    = 1'b1;
      end
      OP_HOST_RD: begin
        host_addr_i = v.ofs;
        host_rd_i   = 1'b1;
        // read data is combinational, sample mid low phase
        #2;
        if (v.ofs == `REG_STATUS) begin
          check_status(bridge_pkg::host_status_t'(host_rdata_o[7:0]),
                       bridge_pkg::host_status_t'(v.exp[7:0]), {tag, " host status"});
        end else begin
          check_word(host_rdata_o, v.exp, {tag, " host read"});
        end
      end
      default: begin
        // no response left over from an earlier request
        check_flag(obi_rvalid_o, 1'b0, {tag, " idle rvalid"});
        obi_req_i   = 1'b1;
        obi_we_i    = (v.op == OP_BUS_WR);
        obi_be_i    = v.be;
        obi_addr_i  = bus_address(v.ofs);
        obi_wdata_i = v.data;
        #2;
        check_flag(obi_gnt_o, 1'b1, {tag, " grant"});
        @(negedge heep_clk);
        drive_idle();
        // response exactly one cycle after the grant
        check_flag(obi_rvalid_o, 1'b1, {tag, " rvalid"});
        if (v.op == OP_BUS_RD) begin
          check_word(obi_rdata_o, v.exp, {tag, " bus read"});
        end
      end
    endcase
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    heep_clk                = 1'b0;
    rst_instr_valid_to_regs = 1'b0;
    host_addr_i             = '0;
    host_wdata_i            = '0;
    obi_be_i                = '0;
    obi_addr_i              = '0;
    obi_wdata_i             = '0;
    drive_idle();

    void'($urandom(32'h8f6e_b0e3));
    instr_a      = $urandom();
    addr_a       = $urandom();
    instr_b      = $urandom();
    result_full  = $urandom();
    result_patch = $urandom();
    fill_vectors();
    cycle_limit = 4 * vecs.size() + 20;

    // two cycles of reset
    repeat (2) @(negedge heep_clk);
    rst_instr_valid_to_regs = 1'b1;

    for (int i = 0; i < vecs.size(); i++) begin
      apply_vector(i);
    end

    @(negedge heep_clk);
    drive_idle();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
